// File: logic/edac_pkg.sv
// SECDED code geometry, read status and check-bit helpers shared by the EDAC encoder and decoder
package edac_pkg;

    localparam int data_width = 26;
    localparam int code_width = 32;
    localparam int syn_width  = 5;

    typedef enum logic [1:0] {
        st_clean         = 2'd0,
        st_corrected     = 2'd1,
        st_uncorrectable = 2'd2
    } status_t;

    // parity over the positions whose index has bit k set
    function automatic logic [syn_width-1:0] calc_syndrome(input logic [code_width-1:0] cw);
        logic [syn_width-1:0] syn;
        syn = '0;
        for (int i = 1; i < code_width; i++) begin
            for (int k = 0; k < syn_width; k++) begin
                if (((i >> k) & 1) != 0) begin
                    syn[k] = syn[k] ^ cw[i];
                end
            end
        end
        return syn;
    endfunction

    // data bits sit in the non power of two positions, ascending
    function automatic logic [data_width-1:0] get_data(input logic [code_width-1:0] cw);
        logic [data_width-1:0] data;
        int unsigned           d;
        data = '0;
        d    = 0;
        for (int i = 1; i < code_width; i++) begin
            if ((i & (i - 1)) != 0) begin
                data[d] = cw[i];
                d++;
            end
        end
        return data;
    endfunction

    function automatic logic [code_width-1:0] make_codeword(input logic [data_width-1:0] data);
        logic [code_width-1:0] cw;
        logic [syn_width-1:0]  chk;
        int unsigned           d;
        cw = '0;
        d  = 0;
        for (int i = 1; i < code_width; i++) begin
            if ((i & (i - 1)) != 0) begin
                cw[i] = data[d];
                d++;
            end
        end
        // check positions are still zero here
        chk = calc_syndrome(cw);
        for (int k = 0; k < syn_width; k++) begin
            cw[1 << k] = chk[k];
        end
        cw[0] = ^cw[code_width-1:1];
        return cw;
    endfunction

endpackage

// File: logic/secded_encoder.sv
// SECDED encoder for the write path, one registered stage between a valid/ready input and output
module secded_encoder (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           wr_valid,
    output logic                           wr_ready,
    input  logic [edac_pkg::data_width-1:0] wr_data,
    output logic                           cw_valid,
    input  logic                           cw_ready,
    output logic [edac_pkg::code_width-1:0] cw_out
);
    import edac_pkg::*;

    // held low through reset, set on the first cycle after it
    logic run;

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // free when empty or being drained this cycle
    assign wr_ready = run & (~cw_valid | cw_ready);

    always_ff @(posedge clk) begin
        if (rst) begin
            cw_valid <= 1'b0;
        end else if (wr_ready) begin
            cw_valid <= wr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid && wr_ready) begin
            cw_out <= make_codeword(wr_data);
        end
    end

endmodule

// File: logic/secded_decoder.sv
// SECDED decoder for the read path, three pipeline stages with one common stall and valid/ready
module secded_decoder (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            rd_valid,
    output logic                            rd_ready,
    input  logic [edac_pkg::code_width-1:0] rd_code,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [edac_pkg::data_width-1:0] out_data,
    output edac_pkg::status_t               out_status,
    output logic                            done
);
    import edac_pkg::*;

    logic                  run;
    logic                  advance;

    // stage 1, raw codeword
    logic                  v1;
    logic [code_width-1:0] code1;

    // stage 2, codeword with its syndrome and overall parity
    logic                  v2;
    logic [code_width-1:0] code2;
    logic [syn_width-1:0]  syn2;
    logic                  par_bad2;

    // stage 3 inputs, worked out from stage 2
    logic [code_width-1:0] fixed;
    status_t               status_c;

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else begin
            run <= 1'b1;
        end
    end

    // whole pipeline moves together or not at all
    assign advance  = out_ready | ~out_valid;
    assign rd_ready = run & advance;
    assign done     = out_valid & out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            v1        <= 1'b0;
            v2        <= 1'b0;
            out_valid <= 1'b0;
        end else if (advance) begin
            v1        <= rd_valid & rd_ready;
            v2        <= v1;
            out_valid <= v2;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            code1 <= rd_code;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            code2    <= code1;
            syn2     <= calc_syndrome(code1);
            par_bad2 <= ^code1;
        end
    end

    always_comb begin
        fixed = code2;
        if (par_bad2) begin
            // syndrome 0 with bad parity means bit 0 itself flipped
            fixed[syn2] = ~code2[syn2];
        end
        if (par_bad2) begin
            status_c = st_corrected;
        end else if (syn2 != '0) begin
            // even number of flips, leave the word as it came in
            status_c = st_uncorrectable;
        end else begin
            status_c = st_clean;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_data   <= get_data(fixed);
            out_status <= status_c;
        end
    end

endmodule

// File: logic/edac_stats.sv
// error statistics for the decoder, saturating counts of corrected and uncorrectable words
module edac_stats #(
    parameter int count_width = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   done,
    input  edac_pkg::status_t      status,
    output logic [count_width-1:0] corrected_count,
    output logic [count_width-1:0] uncorrectable_count
);
    import edac_pkg::*;

    logic corr_full;
    logic uncorr_full;

    // stop at all ones instead of wrapping
    assign corr_full   = &corrected_count;
    assign uncorr_full = &uncorrectable_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            corrected_count <= '0;
        end else if (done && status == st_corrected && !corr_full) begin
            corrected_count <= corrected_count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uncorrectable_count <= '0;
        end else if (done && status == st_uncorrectable && !uncorr_full) begin
            uncorrectable_count <= uncorrectable_count + 1'b1;
        end
    end

endmodule

// File: logic/edac_top.sv
// EDAC top level, independent write encoder and read decoder with error statistics
module edac_top #(
    parameter int count_width = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    // write path
    input  logic                            wr_valid,
    output logic                            wr_ready,
    input  logic [edac_pkg::data_width-1:0] wr_data,
    output logic                            cw_valid,
    input  logic                            cw_ready,
    output logic [edac_pkg::code_width-1:0] cw_out,
    // read path
    input  logic                            rd_valid,
    output logic                            rd_ready,
    input  logic [edac_pkg::code_width-1:0] rd_code,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [edac_pkg::data_width-1:0] out_data,
    output edac_pkg::status_t               out_status,
    // statistics
    output logic [count_width-1:0]          corrected_count,
    output logic [count_width-1:0]          uncorrectable_count
);

    // one pulse per result handed off
    logic done;

    secded_encoder u_encoder (
        .clk      (clk),
        .rst      (rst),
        .wr_valid (wr_valid),
        .wr_ready (wr_ready),
        .wr_data  (wr_data),
        .cw_valid (cw_valid),
        .cw_ready (cw_ready),
        .cw_out   (cw_out)
    );

    secded_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .rd_valid   (rd_valid),
        .rd_ready   (rd_ready),
        .rd_code    (rd_code),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_status (out_status),
        .done       (done)
    );

    edac_stats #(
        .count_width (count_width)
    ) u_stats (
        .clk                 (clk),
        .rst                 (rst),
        .done                (done),
        .status              (out_status),
        .corrected_count     (corrected_count),
        .uncorrectable_count (uncorrectable_count)
    );

endmodule

// File: verification/edac_properties.sv
// handshake and counter assertions for edac_top, attached to every edac_top instance by bind
module edac_properties #(
    parameter int count_width = 16
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            cw_valid,
    input  logic                            cw_ready,
    input  logic [edac_pkg::code_width-1:0] cw_out,
    input  logic                            out_valid,
    input  logic                            out_ready,
    input  logic [edac_pkg::data_width-1:0] out_data,
    input  edac_pkg::status_t               out_status,
    input  logic [count_width-1:0]          corrected_count,
    input  logic [count_width-1:0]          uncorrectable_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // stalled outputs keep their word
    assert property (@(posedge clk) disable iff (rst)
        cw_valid && !cw_ready |=> cw_valid && $stable(cw_out))
        else $error("codeword output changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_status))
        else $error("read output changed while stalled");

    assert property (@(posedge clk) disable iff (rst)
        corrected_count >= $past(corrected_count))
        else $error("corrected count went down");

    assert property (@(posedge clk) disable iff (rst)
        uncorrectable_count >= $past(uncorrectable_count))
        else $error("uncorrectable count went down");

    assert property (@(posedge clk) rst |=> !out_valid)
        else $error("out_valid high right after reset");

endmodule

bind edac_top edac_properties #(
    .count_width (count_width)
) u_properties (
    .clk                 (clk),
    .rst                 (rst),
    .cw_valid            (cw_valid),
    .cw_ready            (cw_ready),
    .cw_out              (cw_out),
    .out_valid           (out_valid),
    .out_ready           (out_ready),
    .out_data            (out_data),
    .out_status          (out_status),
    .corrected_count     (corrected_count),
    .uncorrectable_count (uncorrectable_count)
);

// File: verification/edac_tb.sv
// testbench for edac_top, writes random words, feeds the codewords back with bit flips and checks results
module edac_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import edac_pkg::*;

    // small counters so that saturation is reached within the run
    localparam int count_width    = 6;
    localparam int num_words      = 240;
    localparam int run_cycles     = 2 * num_words + 16;
    localparam int timeout_cycles = 20 * run_cycles;

    logic                   clk;
    logic                   rst;
    logic                   wr_valid;
    logic                   wr_ready;
    logic [data_width-1:0]  wr_data;
    logic                   cw_valid;
    logic                   cw_ready;
    logic [code_width-1:0]  cw_out;
    logic                   rd_valid;
    logic                   rd_ready;
    logic [code_width-1:0]  rd_code;
    logic                   out_valid;
    logic                   out_ready;
    logic [data_width-1:0]  out_data;
    status_t                out_status;
    logic [count_width-1:0] corrected_count;
    logic [count_width-1:0] uncorrectable_count;

    logic [data_width-1:0]  data_q[$];
    logic [code_width-1:0]  code_q[$];
    logic [data_width-1:0]  exp_data_q[$];
    status_t                exp_status_q[$];
    int                     exp_corr;
    int                     exp_uncorr;
    int                     checks;
    int                     errors;

    edac_top #(
        .count_width (count_width)
    ) dut (
        .clk                 (clk),
        .rst                 (rst),
        .wr_valid            (wr_valid),
        .wr_ready            (wr_ready),
        .wr_data             (wr_data),
        .cw_valid            (cw_valid),
        .cw_ready            (cw_ready),
        .cw_out              (cw_out),
        .rd_valid            (rd_valid),
        .rd_ready            (rd_ready),
        .rd_code             (rd_code),
        .out_valid           (out_valid),
        .out_ready           (out_ready),
        .out_data            (out_data),
        .out_status          (out_status),
        .corrected_count     (corrected_count),
        .uncorrectable_count (uncorrectable_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // check bits as the xor of the indices of all set data positions
    function automatic logic [code_width-1:0] ref_encode(input logic [data_width-1:0] data);
        logic [code_width-1:0] cw;
        logic [syn_width-1:0]  chk;
        int                    d;
        cw  = '0;
        chk = '0;
        d   = 0;
        for (int pos = 3; pos < code_width; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                cw[pos] = data[d];
                if (data[d]) begin
                    chk = chk ^ syn_width'(pos);
                end
                d++;
            end
        end
        for (int k = 0; k < syn_width; k++) begin
            cw[1 << k] = chk[k];
        end
        cw[0] = ^cw[code_width-1:1];
        return cw;
    endfunction

    function automatic logic [data_width-1:0] ref_extract(input logic [code_width-1:0] cw);
        logic [data_width-1:0] data;
        int                    d;
        data = '0;
        d    = 0;
        for (int pos = 3; pos < code_width; pos++) begin
            if ((pos & (pos - 1)) != 0) begin
                data[d] = cw[pos];
                d++;
            end
        end
        return data;
    endfunction

    function automatic logic [count_width-1:0] capped(input int n);
        int max_count;
        max_count = (1 << count_width) - 1;
        if (n > max_count) begin
            return count_width'(max_count);
        end
        return count_width'(n);
    endfunction

    task automatic check_code(input string name, input logic [code_width-1:0] exp,
                              input logic [code_width-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input logic [data_width-1:0] exp,
                              input logic [data_width-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_status(input string name, input status_t exp, input status_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %s, actual %s", name, exp.name(), act.name());
        end
    endtask

    task automatic check_count(input string name, input logic [count_width-1:0] exp,
                               input logic [count_width-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic write_words();
        for (int i = 0; i < num_words; i++) begin
            wr_valid <= 1'b1;
            wr_data  <= data_q[i];
            @(posedge clk);
            while (!wr_ready) begin
                @(posedge clk);
            end
        end
        wr_valid <= 1'b0;
    endtask

    task automatic collect_codewords();
        int n;
        n = 0;
        while (n < num_words) begin
            cw_ready <= ($urandom_range(0, 9) >= 3);
            @(posedge clk);
            if (cw_valid && cw_ready) begin
                check_code($sformatf("codeword %0d", n), ref_encode(data_q[n]), cw_out);
                code_q.push_back(cw_out);
                n++;
            end
        end
        cw_ready <= 1'b0;
    endtask

    // 0, 1 or 2 distinct flipped bits per word
    task automatic read_words();
        logic [code_width-1:0] code;
        int                    flips;
        int                    p1;
        int                    p2;
        for (int i = 0; i < num_words; i++) begin
            code  = code_q[i];
            flips = $urandom_range(0, 2);
            p1    = $urandom_range(0, code_width - 1);
            p2    = p1;
            while (p2 == p1) begin
                p2 = $urandom_range(0, code_width - 1);
            end
            if (flips >= 1) begin
                code[p1] = ~code[p1];
            end
            if (flips == 2) begin
                code[p2] = ~code[p2];
                exp_data_q.push_back(ref_extract(code));
                exp_status_q.push_back(st_uncorrectable);
                exp_uncorr++;
            end else begin
                exp_data_q.push_back(data_q[i]);
                exp_status_q.push_back(flips == 1 ? st_corrected : st_clean);
                if (flips == 1) begin
                    exp_corr++;
                end
            end
            rd_valid <= 1'b1;
            rd_code  <= code;
            @(posedge clk);
            while (!rd_ready) begin
                @(posedge clk);
            end
        end
        rd_valid <= 1'b0;
    endtask

    task automatic check_results();
        status_t exp_st;
        int      n;
        int      seen_corr;
        int      seen_uncorr;
        n           = 0;
        seen_corr   = 0;
        seen_uncorr = 0;
        while (n < num_words) begin
            out_ready <= ($urandom_range(0, 9) >= 3);
            @(posedge clk);
            if (out_valid && out_ready) begin
                if (exp_data_q.size() == 0) begin
                    errors++;
                    $display("ERROR: a result came out while no word was outstanding");
                end else begin
                    // counters hold every result handed off before this one
                    check_count($sformatf("read %0d corrected count", n), capped(seen_corr),
                                corrected_count);
                    check_count($sformatf("read %0d uncorrectable count", n),
                                capped(seen_uncorr), uncorrectable_count);
                    exp_st = exp_status_q.pop_front();
                    check_data($sformatf("read %0d data", n), exp_data_q.pop_front(), out_data);
                    check_status($sformatf("read %0d status", n), exp_st, out_status);
                    if (exp_st == st_corrected) begin
                        seen_corr++;
                    end else if (exp_st == st_uncorrectable) begin
                        seen_uncorr++;
                    end
                end
                n++;
            end
        end
        out_ready <= 1'b1;
    endtask

    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("ERROR: timeout, the run did not finish within %0d cycles", timeout_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        void'($urandom(3393));
        rst       <= 1'b1;
        wr_valid  <= 1'b0;
        wr_data   <= '0;
        cw_ready  <= 1'b0;
        rd_valid  <= 1'b0;
        rd_code   <= '0;
        out_ready <= 1'b0;
        checks     = 0;
        errors     = 0;
        exp_corr   = 0;
        exp_uncorr = 0;
        for (int i = 0; i < num_words; i++) begin
            data_q.push_back(data_width'($urandom()));
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        fork
            write_words();
            collect_codewords();
        join

        fork
            read_words();
            check_results();
        join

        // counts land one cycle after the last hand-off
        @(posedge clk);
        if (out_valid) begin
            errors++;
            $display("ERROR: an extra result came out after the last word");
        end
        check_count("corrected count", capped(exp_corr), corrected_count);
        check_count("uncorrectable count", capped(exp_uncorr), uncorrectable_count);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: edac_top.f
logic/edac_pkg.sv
logic/secded_encoder.sv
logic/secded_decoder.sv
logic/edac_stats.sv
logic/edac_top.sv
verification/edac_properties.sv
verification/edac_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the EDAC testbench with Verilator, run it and judge the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module edac_tb \
    -f edac_top.f \
    -o edac_sim

./obj_dir/edac_sim 2>&1 | tee sim.log

if grep -q "Done: errors found" sim.log; then
    echo "simulation reported failures"
    exit 1
fi

if ! grep -q "Done: no errors" sim.log; then
    echo "simulation ended without a final report"
    exit 1
fi

echo "simulation passed"
